/* design/noc_cfg_pkg.sv */
package noc_cfg_pkg;

    // mesh geometry
    localparam int NX = 4;
    localparam int NY = 4;

    localparam int NUM_VC   = 4;
    localparam int VC_DEPTH = 4;   // flits per VC at the receiver

    // packets run from 2 flits up to this
    localparam int MAX_PCK_SIZ   = 10;
    localparam int TS_FIFO_DEPTH = 16;
    localparam int RATIO_MAX     = 100;

    localparam int TS_PTR_W = $clog2(TS_FIFO_DEPTH);
    localparam int CRED_W   = $clog2(VC_DEPTH + 1);
    localparam int VC_IDX_W = $clog2(NUM_VC);
    localparam int STATE_W  = $clog2(2 * MAX_PCK_SIZ * RATIO_MAX + 1);  // on/off accumulator

    typedef logic [1:0]        coord_x_t;
    typedef logic [1:0]        coord_y_t;
    typedef logic [6:0]        ratio_t;
    typedef logic [3:0]        pck_size_t;
    typedef logic [1:0]        class_t;
    typedef logic [NUM_VC-1:0] vc_mask_t;
    typedef logic [15:0]       stamp_t;    // wraps
    typedef logic [15:0]       pck_num_t;
    typedef logic [3:0]        distance_t;

endpackage

/* design/flit_pkg.sv */
package flit_pkg;

    import noc_cfg_pkg::*;

    localparam int FLAG_W    = 2;
    localparam int PAYLOAD_W = 32;

    // high bit marks a header, low bit a tail
    localparam logic [FLAG_W-1:0] FLAG_HDR  = 2'b10;
    localparam logic [FLAG_W-1:0] FLAG_TAIL = 2'b01;
    localparam logic [FLAG_W-1:0] FLAG_BODY = 2'b00;

    localparam int HDR_CLASS_W = 8;
    localparam int HDR_PORT_W  = 8;
    localparam int HDR_XY_W    = 4;

    typedef struct packed {
        logic [FLAG_W-1:0]    flags;
        vc_mask_t             vc;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // header payload, top field first
    typedef struct packed {
        logic [HDR_CLASS_W-1:0] pck_class;
        logic [HDR_PORT_W-1:0]  port;       // reserved, zero
        logic [HDR_XY_W-1:0]    dest_x;
        logic [HDR_XY_W-1:0]    dest_y;
        logic [HDR_XY_W-1:0]    src_x;
        logic [HDR_XY_W-1:0]    src_y;
    } hdr_payload_t;

endpackage

/* design/injection_ratio_ctrl.sv */
`timescale 1ns/1ps

module injection_ratio_ctrl
    import noc_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  ratio_t    ratio,
    input  pck_size_t pck_size,
    input  logic      freeze,
    output logic      pck_wr,
    output stamp_t    cycle_count
);

    localparam logic [STATE_W-1:0] STATE_INIT = STATE_W'(MAX_PCK_SIZ * RATIO_MAX);

    logic               enable;
    logic               on_phase, on_phase_nxt;
    logic [STATE_W-1:0] state, state_nxt;
    logic [STATE_W-1:0] off_step;
    pck_size_t          flit_cnt, flit_cnt_nxt;
    ratio_t             ratio_q;
    logic               ratio_chg;
    logic               active;

    assign ratio_chg = (ratio != ratio_q);
    assign active    = enable && !freeze && (ratio != '0) && !ratio_chg;
    assign off_step  = STATE_W'(RATIO_MAX) - STATE_W'(ratio);
    assign pck_wr    = active && on_phase && (flit_cnt == '0);  // first flit slot of a packet

    always_comb begin
        state_nxt    = state;
        flit_cnt_nxt = flit_cnt;
        on_phase_nxt = on_phase;
        if (active) begin
            if (on_phase) begin
                state_nxt = state + off_step;
                if (flit_cnt >= pck_size - 1'b1) begin
                    flit_cnt_nxt = '0;
                    // only leave the on phase at a packet boundary
                    if (state_nxt > STATE_INIT)
                        on_phase_nxt = 1'b0;
                end else begin
                    flit_cnt_nxt = flit_cnt + 1'b1;
                end
            end else begin
                state_nxt = state - STATE_W'(ratio);
                if (state_nxt <= STATE_INIT)
                    on_phase_nxt = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable      <= 1'b0;
            ratio_q     <= '0;
            state       <= STATE_INIT;
            on_phase    <= 1'b1;
            flit_cnt    <= '0;
            cycle_count <= '0;
        end else begin
            enable      <= enable | start;
            ratio_q     <= ratio;
            cycle_count <= cycle_count + 1'b1;
            if (ratio_chg) begin  // new ratio restarts the profile
                state    <= STATE_INIT;
                on_phase <= 1'b1;
                flit_cnt <= '0;
            end else begin
                state    <= state_nxt;
                on_phase <= on_phase_nxt;
                flit_cnt <= flit_cnt_nxt;
            end
        end
    end

endmodule

/* design/timestamp_fifo.sv */
`timescale 1ns/1ps

module timestamp_fifo
    import noc_cfg_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  stamp_t din,
    input  logic   wr_en,
    input  logic   rd_en,
    output stamp_t dout,
    output logic   full,
    output logic   empty
);

    stamp_t              mem [TS_FIFO_DEPTH];
    logic [TS_PTR_W-1:0] wr_ptr;
    logic [TS_PTR_W-1:0] rd_ptr;
    logic [TS_PTR_W:0]   count;

    assign full  = (count == (TS_PTR_W + 1)'(TS_FIFO_DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];  // show-ahead

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
        else $error("timestamp FIFO written while full");

    a_no_read_empty: assert property (@(posedge clk) disable iff (reset) !(rd_en && empty))
        else $error("timestamp FIFO read while empty");

endmodule

/* design/ovc_credit_tracker.sv */
`timescale 1ns/1ps

module ovc_credit_tracker
    import noc_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  vc_mask_t flit_wr_vc,
    input  vc_mask_t credit_in,
    input  logic     cand_en,
    output vc_mask_t credit_avail,
    output vc_mask_t cand_vc
);

    logic [CRED_W-1:0]   credit_cnt [NUM_VC];
    logic [VC_IDX_W-1:0] last_vc;   // last VC handed out
    logic [VC_IDX_W-1:0] cand_idx;

    always_comb begin
        for (int i = 0; i < NUM_VC; i++) begin
            credit_avail[i] = (credit_cnt[i] != '0);
        end
    end

    // round robin, first VC with credit after last_vc wins
    always_comb begin
        logic [VC_IDX_W-1:0] idx;
        cand_vc  = '0;
        cand_idx = last_vc;
        for (int k = NUM_VC; k >= 1; k--) begin
            idx = last_vc + VC_IDX_W'(k);
            if (credit_avail[idx]) begin
                cand_vc  = vc_mask_t'(1) << idx;
                cand_idx = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_VC; i++) begin
                credit_cnt[i] <= CRED_W'(VC_DEPTH);
            end
            last_vc <= '0;
        end else begin
            for (int i = 0; i < NUM_VC; i++) begin
                case ({flit_wr_vc[i], credit_in[i]})
                    2'b10:   credit_cnt[i] <= credit_cnt[i] - 1'b1;
                    2'b01:   credit_cnt[i] <= credit_cnt[i] + 1'b1;
                    default: ;
                endcase
            end
            if (cand_en && (cand_vc != '0))
                last_vc <= cand_idx;
        end
    end

    // writer and returned credits must agree with the receiver depth
    for (genvar i = 0; i < NUM_VC; i++) begin : g_chk
        a_credit_range: assert property (@(posedge clk) disable iff (reset)
            (credit_cnt[i] <= CRED_W'(VC_DEPTH)) && !(flit_wr_vc[i] && (credit_cnt[i] == '0)))
            else $error("credit count out of range on VC %0d", i);
    end

endmodule

/* design/flit_injector.sv */
`timescale 1ns/1ps

module flit_injector
    import noc_cfg_pkg::*;
    import flit_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fifo_empty,
    input  stamp_t    fifo_stamp,
    output logic      pck_rd,
    input  pck_size_t pck_size_in,
    input  coord_x_t  current_x,
    input  coord_x_t  dest_x,
    input  coord_y_t  current_y,
    input  coord_y_t  dest_y,
    input  class_t    pck_class_in,
    input  vc_mask_t  credit_in,
    output flit_t     flit_out,
    output logic      flit_out_wr,
    output logic      sent_done,
    output pck_num_t  pck_number
);

    typedef enum logic [1:0] {IDLE, SENT, WAIT} state_t;

    state_t       state, state_nxt;
    vc_mask_t     wr_vc, wr_vc_nxt;
    vc_mask_t     flit_wr_vc;
    vc_mask_t     credit_avail;
    vc_mask_t     cand_vc;
    logic         cand_en;
    logic         vc_ready, valid_dst, is_tail;
    logic         cnt_inc, cnt_clr;
    pck_size_t    flit_cnt;
    pck_size_t    pck_size;    // latched at the header
    stamp_t       pck_stamp;
    hdr_payload_t hdr;

    assign valid_dst = ((dest_x != current_x) || (dest_y != current_y))
                     && (int'(dest_x) < NX) && (int'(dest_y) < NY);
    assign vc_ready   = |(wr_vc & credit_avail);
    assign is_tail    = (state == SENT) && (flit_cnt == pck_size - 1'b1);
    assign flit_wr_vc = flit_out_wr ? wr_vc : '0;

    assign hdr = '{pck_class: HDR_CLASS_W'(pck_class_in),
                   port:      '0,
                   dest_x:    HDR_XY_W'(dest_x),
                   dest_y:    HDR_XY_W'(dest_y),
                   src_x:     HDR_XY_W'(current_x),
                   src_y:     HDR_XY_W'(current_y)};

    always_comb begin
        flit_out.vc = wr_vc;
        if (state == IDLE) begin
            flit_out.flags   = FLAG_HDR;
            flit_out.payload = hdr;
        end else if (is_tail) begin
            flit_out.flags   = FLAG_TAIL;
            flit_out.payload = PAYLOAD_W'(pck_stamp);
        end else begin
            flit_out.flags   = FLAG_BODY;
            flit_out.payload = {pck_num_t'(pck_number - 1'b1), 16'(flit_cnt)};  // count moved at header
        end
    end

    always_comb begin
        state_nxt   = state;
        wr_vc_nxt   = wr_vc;
        flit_out_wr = 1'b0;
        pck_rd      = 1'b0;
        sent_done   = 1'b0;
        cand_en     = 1'b0;
        cnt_inc     = 1'b0;
        cnt_clr     = 1'b0;
        case (state)
            IDLE: begin
                if (!fifo_empty && vc_ready && valid_dst) begin
                    flit_out_wr = 1'b1;
                    pck_rd      = 1'b1;
                    cnt_inc     = 1'b1;
                    state_nxt   = SENT;
                end
            end
            SENT: begin
                if (vc_ready) begin  // otherwise hold the flit
                    flit_out_wr = 1'b1;
                    if (is_tail) begin
                        sent_done = 1'b1;
                        cnt_clr   = 1'b1;
                        cand_en   = 1'b1;
                        if (cand_vc != '0) begin
                            wr_vc_nxt = cand_vc;
                            state_nxt = IDLE;
                        end else begin
                            state_nxt = WAIT;
                        end
                    end else begin
                        cnt_inc = 1'b1;
                    end
                end
            end
            WAIT: begin
                cand_en = 1'b1;
                if (cand_vc != '0) begin
                    wr_vc_nxt = cand_vc;
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            wr_vc      <= vc_mask_t'(1);
            flit_cnt   <= '0;
            pck_number <= '0;
        end else begin
            state <= state_nxt;
            wr_vc <= wr_vc_nxt;
            if (cnt_clr)
                flit_cnt <= '0;
            else if (cnt_inc)
                flit_cnt <= flit_cnt + 1'b1;
            if (pck_rd)
                pck_number <= pck_number + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pck_rd) begin
            pck_size  <= pck_size_in;
            pck_stamp <= fifo_stamp;
        end
    end

    ovc_credit_tracker i_ovc_credit_tracker (
        .clk          (clk),
        .reset        (reset),
        .flit_wr_vc   (flit_wr_vc),
        .credit_in    (credit_in),
        .cand_en      (cand_en),
        .credit_avail (credit_avail),
        .cand_vc      (cand_vc)
    );

endmodule

/* design/packet_sink.sv */
`timescale 1ns/1ps

module packet_sink
    import noc_cfg_pkg::*;
    import flit_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coord_x_t  current_x,
    input  coord_y_t  current_y,
    input  flit_t     flit_in,
    input  logic      flit_in_wr,
    output vc_mask_t  credit_out,
    output logic      update,
    output class_t    pck_class_out,
    output distance_t distance,
    output stamp_t    time_stamp_h2h,
    output stamp_t    time_stamp_h2t
);

    // per-VC record of the packet in flight
    coord_x_t            src_x    [NUM_VC];
    coord_y_t            src_y    [NUM_VC];
    class_t              pck_cls  [NUM_VC];
    stamp_t              hdr_time [NUM_VC];

    stamp_t              cycle_count;  // tracks the producer's counter
    logic [VC_IDX_W-1:0] rd_vc;
    hdr_payload_t        hdr;
    stamp_t              tail_stamp;
    logic                hdr_in, tail_in;
    coord_x_t            dx;
    coord_y_t            dy;

    assign hdr        = hdr_payload_t'(flit_in.payload);
    assign tail_stamp = flit_in.payload[$bits(stamp_t)-1:0];
    assign hdr_in     = flit_in_wr && (flit_in.flags == FLAG_HDR);
    assign tail_in    = flit_in_wr && (flit_in.flags == FLAG_TAIL);

    always_comb begin
        rd_vc = '0;
        for (int i = 0; i < NUM_VC; i++) begin
            if (flit_in.vc[i])
                rd_vc = VC_IDX_W'(i);
        end
    end

    // mesh hops back to the source
    assign dx = (src_x[rd_vc] > current_x) ? src_x[rd_vc] - current_x
                                           : current_x - src_x[rd_vc];
    assign dy = (src_y[rd_vc] > current_y) ? src_y[rd_vc] - current_y
                                           : current_y - src_y[rd_vc];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_out  <= '0;
            update      <= 1'b0;
            cycle_count <= '0;
        end else begin
            credit_out  <= flit_in_wr ? flit_in.vc : '0;  // one credit per flit
            update      <= tail_in;
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_in) begin
            src_x[rd_vc]    <= coord_x_t'(hdr.src_x);
            src_y[rd_vc]    <= coord_y_t'(hdr.src_y);
            pck_cls[rd_vc]  <= class_t'(hdr.pck_class);
            hdr_time[rd_vc] <= cycle_count;
        end
        if (tail_in) begin
            pck_class_out  <= pck_cls[rd_vc];
            distance       <= distance_t'(dx) + distance_t'(dy) + 1'b1;
            time_stamp_h2h <= hdr_time[rd_vc] - tail_stamp;
            time_stamp_h2t <= cycle_count - tail_stamp;
        end
    end

endmodule

/* design/traffic_gen.sv */
`timescale 1ns/1ps

module traffic_gen
    import noc_cfg_pkg::*;
    import flit_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  ratio_t    ratio,
    input  pck_size_t pck_size_in,
    input  coord_x_t  current_x,
    input  coord_y_t  current_y,
    input  coord_x_t  dest_x,
    input  coord_y_t  dest_y,
    input  class_t    pck_class_in,
    output pck_num_t  pck_number,
    output logic      sent_done,
    output logic      hdr_flit_sent,
    output logic      update,
    output distance_t distance,
    output class_t    pck_class_out,
    output stamp_t    time_stamp_h2h,
    output stamp_t    time_stamp_h2t,
    output flit_t     flit_out,
    output logic      flit_out_wr,
    input  vc_mask_t  credit_in,
    input  flit_t     flit_in,
    input  logic      flit_in_wr,
    output vc_mask_t  credit_out
);

    logic   pck_wr;
    logic   fifo_full;
    logic   fifo_empty;
    stamp_t cycle_count;
    stamp_t fifo_stamp;

    injection_ratio_ctrl i_injection_ratio_ctrl (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .ratio       (ratio),
        .pck_size    (pck_size_in),
        .freeze      (fifo_full),
        .pck_wr      (pck_wr),
        .cycle_count (cycle_count)
    );

    // header read pops the creation time
    timestamp_fifo i_timestamp_fifo (
        .clk   (clk),
        .reset (reset),
        .din   (cycle_count),
        .wr_en (pck_wr),
        .rd_en (hdr_flit_sent),
        .dout  (fifo_stamp),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    flit_injector i_flit_injector (
        .clk          (clk),
        .reset        (reset),
        .fifo_empty   (fifo_empty),
        .fifo_stamp   (fifo_stamp),
        .pck_rd       (hdr_flit_sent),
        .pck_size_in  (pck_size_in),
        .current_x    (current_x),
        .dest_x       (dest_x),
        .current_y    (current_y),
        .dest_y       (dest_y),
        .pck_class_in (pck_class_in),
        .credit_in    (credit_in),
        .flit_out     (flit_out),
        .flit_out_wr  (flit_out_wr),
        .sent_done    (sent_done),
        .pck_number   (pck_number)
    );

    packet_sink i_packet_sink (
        .clk            (clk),
        .reset          (reset),
        .current_x      (current_x),
        .current_y      (current_y),
        .flit_in        (flit_in),
        .flit_in_wr     (flit_in_wr),
        .credit_out     (credit_out),
        .update         (update),
        .pck_class_out  (pck_class_out),
        .distance       (distance),
        .time_stamp_h2h (time_stamp_h2h),
        .time_stamp_h2t (time_stamp_h2t)
    );

endmodule

/* dv/traffic_gen_tb.sv */
`timescale 1ns/1ps

module traffic_gen_tb
    import noc_cfg_pkg::*;
    import flit_pkg::*;
();

    localparam int NUM_PCK   = 60;
    localparam int MAX_CYCLE = 20 * NUM_PCK * MAX_PCK_SIZ + 2000;

    logic      clk, reset, start, flit_out_wr, flit_in_wr;
    logic      sent_done, hdr_flit_sent, update;
    ratio_t    ratio;
    pck_size_t pck_size_in;
    coord_x_t  current_x, dest_x;
    coord_y_t  current_y, dest_y;
    class_t    pck_class_in, pck_class_out;
    pck_num_t  pck_number;
    distance_t distance;
    stamp_t    time_stamp_h2h, time_stamp_h2t;
    flit_t     flit_out, flit_in;
    vc_mask_t  credit_in, credit_out;

    integer    seed = 32'hdf43;
    int        errors = 0;
    int        tb_cyc = 0;     // cycles since reset, same as the DUT counters
    int        hdr_cnt = 0;
    int        tail_cnt = 0;
    int        rx_tails = 0;
    logic      withhold = 1'b0;
    int        tb_credit [NUM_VC];
    int        cred_pend [NUM_VC];
    int        cred_timer [NUM_VC];
    flit_t     loop_q [$];
    int        loop_due [$];
    int        last_due = 0;

    // generator side packet state
    logic      in_pkt = 1'b0;
    int        cur_idx;
    pck_size_t cur_size;
    vc_mask_t  cur_vc;
    class_t    cur_cls;
    stamp_t    cur_stamp;
    pck_num_t  exp_pck = '0;

    // producer model
    stamp_t    stamp_q [$];    // creation stamps waiting in the DUT FIFO
    logic      prod_en = 1'b0;
    ratio_t    prod_ratio_q = '0;
    int        prod_slot = 0;

    // sink side expectations
    coord_x_t  snk_sx [NUM_VC];
    coord_y_t  snk_sy [NUM_VC];
    class_t    snk_cls [NUM_VC];
    stamp_t    snk_hdr_t [NUM_VC];
    logic      prev_wr = 1'b0;
    logic      prev_tail = 1'b0;
    vc_mask_t  prev_vc = '0;
    distance_t exp_dist;
    class_t    exp_cls;
    stamp_t    exp_h2h, exp_h2t;

    traffic_gen i_traffic_gen (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic flit_t exp_flit(pck_num_t pnum, int idx, pck_size_t size, class_t cls,
                                       coord_x_t sx, coord_y_t sy, coord_x_t dx, coord_y_t dy,
                                       stamp_t stamp, vc_mask_t vc);
        flit_t f;
        f.vc = vc;
        if (idx == 0) begin
            f.flags   = 2'b10;
            f.payload = {8'(cls), 8'h00, 4'(dx), 4'(dy), 4'(sx), 4'(sy)};
        end else if (idx == int'(size) - 1) begin
            f.flags   = 2'b01;
            f.payload = {16'h0000, stamp};
        end else begin
            f.flags   = 2'b00;
            f.payload = {pnum, 16'(idx)};
        end
        return f;
    endfunction

    function automatic int vc_index(vc_mask_t m);
        int r;
        r = 0;
        for (int i = 0; i < NUM_VC; i++)
            if (m[i]) r = i;
        return r;
    endfunction

    task automatic check_flit(string name, flit_t got, flit_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_vc(string name, vc_mask_t got, vc_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_stamp(string name, stamp_t got, stamp_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_distance(string name, distance_t got, distance_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_class(string name, class_t got, class_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pck_num(string name, pck_num_t got, pck_num_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fail_msg(string what);
        errors++;
        $display("error at cycle %0d: %s", tb_cyc, what);
    endtask

    // network model, drives loopback flits and credits after each edge
    always @(posedge clk) begin
        if (!reset)
            tb_cyc++;
        #1;
        flit_in_wr = 1'b0;
        flit_in    = '0;
        if (loop_q.size() > 0 && loop_due[0] <= tb_cyc) begin
            flit_in    = loop_q.pop_front();
            flit_in_wr = 1'b1;
            void'(loop_due.pop_front());
        end
        credit_in = '0;
        for (int v = 0; v < NUM_VC; v++) begin
            if (!withhold && cred_pend[v] > 0) begin
                if (cred_timer[v] == 0) begin
                    credit_in[v]  = 1'b1;
                    cred_pend[v]--;
                    cred_timer[v] = $unsigned($random(seed)) % 3;
                end else begin
                    cred_timer[v]--;
                end
            end
        end
    end

    // compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        int   v;
        int   dly;
        logic prod_act;
        if (!reset) begin
            // at full ratio every flit slot is an on slot
            prod_act = prod_en && (ratio != '0) && (ratio == prod_ratio_q)
                     && (stamp_q.size() < TS_FIFO_DEPTH);
            if (flit_out_wr) begin
                v = vc_index(flit_out.vc);
                if (!$onehot(flit_out.vc))
                    fail_msg("flit VC is not one-hot");
                else if (tb_credit[v] == 0)
                    fail_msg("flit sent on a VC with no credit");
                tb_credit[v]--;
                if (!in_pkt) begin
                    if (!hdr_flit_sent)
                        fail_msg("hdr_flit_sent low on a header");
                    if (stamp_q.size() == 0)
                        fail_msg("header sent with no packet queued");
                    else
                        cur_stamp = stamp_q.pop_front();
                    in_pkt   = 1'b1;
                    cur_idx  = 0;
                    cur_size = pck_size_in;
                    cur_vc   = flit_out.vc;
                    cur_cls  = pck_class_in;
                    hdr_cnt++;
                end else begin
                    cur_idx++;
                    if (hdr_flit_sent)
                        fail_msg("hdr_flit_sent high inside a packet");
                end
                check_vc("flit_out.vc", flit_out.vc, cur_vc);
                check_pck_num("pck_number", pck_number,
                              (cur_idx == 0) ? exp_pck : exp_pck + 1'b1);
                check_flit("flit_out", flit_out,
                           exp_flit(exp_pck, cur_idx, cur_size, cur_cls, current_x, current_y,
                                    dest_x, dest_y, cur_stamp, cur_vc));
                if (sent_done !== (cur_idx == int'(cur_size) - 1))
                    fail_msg("sent_done does not mark the tail");
                if (cur_idx == int'(cur_size) - 1) begin
                    in_pkt = 1'b0;
                    exp_pck++;
                    tail_cnt++;
                end
                dly      = 1 + $unsigned($random(seed)) % 3;
                last_due = (tb_cyc + dly > last_due) ? tb_cyc + dly : last_due + 1;
                loop_q.push_back(flit_out);
                loop_due.push_back(last_due);
                cred_pend[v]++;
            end else if (sent_done || hdr_flit_sent) begin
                fail_msg("sent_done or hdr_flit_sent without a flit");
            end
            for (int i = 0; i < NUM_VC; i++)
                if (credit_in[i]) tb_credit[i]++;

            // one packet write per pck_size slots, stamped with the cycle
            if (prod_act) begin
                if (prod_slot == 0)
                    stamp_q.push_back(stamp_t'(tb_cyc));
                prod_slot = (prod_slot >= int'(pck_size_in) - 1) ? 0 : prod_slot + 1;
            end else if (ratio != prod_ratio_q) begin
                prod_slot = 0;  // new ratio restarts the packet
            end
            prod_en      = prod_en | start;
            prod_ratio_q = ratio;

            // sink
            check_vc("credit_out", credit_out, prev_wr ? prev_vc : '0);
            if (update !== prev_tail)
                fail_msg("update does not follow the tail by one cycle");
            if (update && prev_tail) begin
                check_distance("distance", distance, exp_dist);
                check_class("pck_class_out", pck_class_out, exp_cls);
                check_stamp("time_stamp_h2h", time_stamp_h2h, exp_h2h);
                check_stamp("time_stamp_h2t", time_stamp_h2t, exp_h2t);
            end
            prev_wr   = flit_in_wr;
            prev_vc   = flit_in.vc;
            prev_tail = flit_in_wr && flit_in.flags == 2'b01;
            if (flit_in_wr) begin
                v = vc_index(flit_in.vc);
                if (flit_in.flags == 2'b10) begin
                    snk_sx[v]    = coord_x_t'(flit_in.payload[7:4]);
                    snk_sy[v]    = coord_y_t'(flit_in.payload[3:0]);
                    snk_cls[v]   = class_t'(flit_in.payload[31:24]);
                    snk_hdr_t[v] = stamp_t'(tb_cyc);
                end else if (flit_in.flags == 2'b01) begin
                    exp_dist = distance_t'((snk_sx[v] > current_x) ? snk_sx[v] - current_x
                                                                   : current_x - snk_sx[v])
                             + distance_t'((snk_sy[v] > current_y) ? snk_sy[v] - current_y
                                                                   : current_y - snk_sy[v])
                             + 4'd1;
                    exp_cls = snk_cls[v];
                    exp_h2h = snk_hdr_t[v] - flit_in.payload[15:0];
                    exp_h2t = stamp_t'(tb_cyc) - flit_in.payload[15:0];
                    rx_tails++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (tb_cyc >= MAX_CYCLE) begin
            $display("timeout after %0d cycles, traffic did not complete", tb_cyc);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_headers(int n);
        while (hdr_cnt < n)
            @(posedge clk);
        #1;
    endtask

    initial begin
        int snap;
        for (int i = 0; i < NUM_VC; i++) begin
            tb_credit[i]  = VC_DEPTH;
            cred_pend[i]  = 0;
            cred_timer[i] = 0;
        end
        reset = 1'b1;
        start = 1'b0;
        ratio = 7'd100;
        pck_size_in  = 4'd4;
        current_x    = 2'd1;
        current_y    = 2'd2;
        dest_x       = 2'd3;
        dest_y       = 2'd0;
        pck_class_in = 2'd2;
        credit_in    = '0;
        flit_in      = '0;
        flit_in_wr   = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        wait_cycles(500);   // not started yet
        ratio = 7'd0;
        start = 1'b1;
        wait_cycles(1);
        start = 1'b0;
        wait_cycles(500);
        if (hdr_cnt != 0)
            fail_msg("flits sent before start or at ratio 0");

        ratio = 7'd100;
        wait_headers(10);

        // credit stall
        pck_size_in  = 4'd2;
        pck_class_in = 2'd1;
        withhold = 1'b1;
        wait_cycles(100);
        withhold = 1'b0;
        wait_headers(20);

        // node moves onto its destination, the FIFO fills meanwhile
        current_x = dest_x;
        current_y = dest_y;
        snap = hdr_cnt;
        wait_cycles(300);
        if (hdr_cnt != snap)
            fail_msg("header sent to an invalid destination");
        pck_size_in  = 4'd10;
        pck_class_in = 2'd3;
        dest_x = 2'd0;
        dest_y = 2'd3;
        wait_headers(snap + 16);

        ratio = 7'd0;
        wait_cycles(800);
        if (in_pkt || tail_cnt != hdr_cnt || rx_tails != tail_cnt || loop_q.size() != 0
            || stamp_q.size() != 0)
            fail_msg("traffic did not drain completely");

        $display("errors: %0d, packets sent: %0d, received: %0d", errors, tail_cnt, rx_tails);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* sources.f */
design/noc_cfg_pkg.sv
design/flit_pkg.sv
design/injection_ratio_ctrl.sv
design/timestamp_fifo.sv
design/ovc_credit_tracker.sv
design/flit_injector.sv
design/packet_sink.sv
design/traffic_gen.sv
dv/traffic_gen_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module traffic_gen_tb \
    -o traffic_gen_sim > build.log 2>&1 \
    && ./obj_dir/traffic_gen_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
